// File: source/mem_pkg.sv
package mem_pkg;

    // memory geometry.
    localparam int MEM_DEPTH  = 1024;
    localparam int BYTE_WIDTH = 8;
    localparam int BYTE_NUM   = 4;
    localparam int MEM_WIDTH  = BYTE_WIDTH * BYTE_NUM;
    localparam int ADDR_WIDTH = $clog2(MEM_DEPTH);

    // read data is usable at the RD_LAT-th edge after the read edge.
    localparam int RD_LAT      = 3;
    // output registers behind the array read register.
    localparam int PIPE_STAGES = RD_LAT - 1;

    typedef logic [MEM_WIDTH-1:0]  word_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [BYTE_NUM-1:0]   be_t;

    typedef enum logic {
        MOVE_COPY = 1'b0,
        MOVE_FILL = 1'b1
    } move_mode_e;

endpackage

// File: source/ram_port_if.sv
`timescale 1ns/10ps

interface ram_port_if;

    logic           en;
    mem_pkg::be_t   wr_en;
    mem_pkg::addr_t addr;
    mem_pkg::word_t wdata;
    mem_pkg::word_t rdata;

    // requester side.
    modport master (
        output en,
        output wr_en,
        output addr,
        output wdata,
        input  rdata
    );

    // memory side.
    modport slave (
        input  en,
        input  wr_en,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

// File: source/ram_tdp.sv
`timescale 1ns/10ps

module ram_tdp (
    input logic       a_clk_i,
    ram_port_if.slave port_a,
    ram_port_if.slave port_b
);

    mem_pkg::word_t ram [mem_pkg::MEM_DEPTH];

    // both ports gathered into arrays with port a at index 0.
    logic           port_en    [2];
    mem_pkg::be_t   port_wr_en [2];
    mem_pkg::addr_t port_addr  [2];
    mem_pkg::word_t port_wdata [2];
    mem_pkg::word_t port_rdata [2];

    assign port_en[0]    = port_a.en;
    assign port_wr_en[0] = port_a.wr_en;
    assign port_addr[0]  = port_a.addr;
    assign port_wdata[0] = port_a.wdata;

    assign port_en[1]    = port_b.en;
    assign port_wr_en[1] = port_b.wr_en;
    assign port_addr[1]  = port_b.addr;
    assign port_wdata[1] = port_b.wdata;

    assign port_a.rdata = port_rdata[0];
    assign port_b.rdata = port_rdata[1];

    // byte lane writes from both ports.
    always_ff @(posedge a_clk_i) begin
        for (int p = 0; p < 2; p++) begin
            for (int i = 0; i < mem_pkg::BYTE_NUM; i++) begin
                if (port_en[p] && port_wr_en[p][i]) begin
                    ram[port_addr[p]][i*mem_pkg::BYTE_WIDTH +: mem_pkg::BYTE_WIDTH] <=
                        port_wdata[p][i*mem_pkg::BYTE_WIDTH +: mem_pkg::BYTE_WIDTH];
                end
            end
        end
    end

    for (genvar p = 0; p < 2; p++) begin : g_rd_path
        logic                         rd_en;
        mem_pkg::word_t               rd_q;
        mem_pkg::word_t               pipe_q [mem_pkg::PIPE_STAGES];
        logic [mem_pkg::PIPE_STAGES-1:0] vld_q;

        // no_change mode leaves the read register alone on a write cycle.
        assign rd_en = port_en[p] && !(|port_wr_en[p]);

        always_ff @(posedge a_clk_i) begin
            if (rd_en) begin
                rd_q <= ram[port_addr[p]];
            end
        end

        // enable chain follows each read down the pipe.
        always_ff @(posedge a_clk_i) begin
            vld_q[0] <= rd_en;
            for (int i = 1; i < mem_pkg::PIPE_STAGES; i++) begin
                vld_q[i] <= vld_q[i-1];
            end
        end

        always_ff @(posedge a_clk_i) begin
            if (vld_q[0]) begin
                pipe_q[0] <= rd_q;
            end
            for (int i = 1; i < mem_pkg::PIPE_STAGES; i++) begin
                if (vld_q[i]) begin
                    pipe_q[i] <= pipe_q[i-1];
                end
            end
        end

        assign port_rdata[p] = pipe_q[mem_pkg::PIPE_STAGES-1];
    end

    // host and mover must never collide on a write.
    a_no_write_collision: assert property (
        @(posedge a_clk_i)
        (port_a.en && (|port_a.wr_en) && port_b.en && (|port_b.wr_en))
            |-> (port_a.addr != port_b.addr)
    ) else $error("ram_tdp: both ports write address %0d", port_a.addr);

endmodule

// File: source/host_port_ctrl.sv
`timescale 1ns/10ps

module host_port_ctrl (
    input  logic           a_clk_i,
    input  logic           rst_n_i,
    input  logic           host_en_i,
    input  mem_pkg::be_t   host_wr_en_i,
    input  mem_pkg::addr_t host_addr_i,
    input  mem_pkg::word_t host_wdata_i,
    output mem_pkg::word_t host_rdata_o,
    output logic           host_rvalid_o,
    ram_port_if.master     port
);

    logic                         rd_issue;
    logic [mem_pkg::RD_LAT-1:0]   rd_flag_q;

    assign port.en    = host_en_i;
    assign port.wr_en = host_wr_en_i;
    assign port.addr  = host_addr_i;
    assign port.wdata = host_wdata_i;

    assign rd_issue = host_en_i && !(|host_wr_en_i);

    // one flag per read in flight.
    always_ff @(posedge a_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_flag_q <= '0;
        end else begin
            rd_flag_q <= {rd_flag_q[mem_pkg::RD_LAT-2:0], rd_issue};
        end
    end

    assign host_rvalid_o = rd_flag_q[mem_pkg::RD_LAT-1];
    assign host_rdata_o  = port.rdata;

    a_rvalid_has_read: assert property (
        @(posedge a_clk_i) disable iff (!rst_n_i)
        host_rvalid_o |-> $past(rd_issue, mem_pkg::RD_LAT)
    ) else $error("host_port_ctrl: read valid without a matching read");

endmodule

// File: source/block_mover.sv
`timescale 1ns/10ps

module block_mover (
    input  logic                          a_clk_i,
    input  logic                          rst_n_i,
    input  logic                          start_i,
    input  mem_pkg::move_mode_e           mode_i,
    input  mem_pkg::addr_t                src_i,
    input  mem_pkg::addr_t                dst_i,
    input  logic [mem_pkg::ADDR_WIDTH:0]  len_i,
    input  mem_pkg::word_t                pattern_i,
    output logic                          busy_o,
    output logic                          done_o,
    ram_port_if.master                    port
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,
        ST_WAIT,
        ST_WRITE
    } state_e;

    state_e                               state_q;
    mem_pkg::addr_t                       off_q;
    logic [$clog2(mem_pkg::RD_LAT)-1:0]   lat_cnt_q;
    logic                                 done_q;
    logic                                 start_ok;
    logic                                 last_word;

    // command held for the whole move.
    mem_pkg::move_mode_e                  mode_q;
    mem_pkg::addr_t                       src_q;
    mem_pkg::addr_t                       dst_q;
    logic [mem_pkg::ADDR_WIDTH:0]         len_q;
    mem_pkg::word_t                       pattern_q;

    assign start_ok  = (state_q == ST_IDLE) && start_i;
    assign last_word = ({1'b0, off_q} == (len_q - 1'b1));

    always_ff @(posedge a_clk_i) begin
        if (start_ok) begin
            mode_q    <= mode_i;
            src_q     <= src_i;
            dst_q     <= dst_i;
            len_q     <= len_i;
            pattern_q <= pattern_i;
        end
    end

    always_ff @(posedge a_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= ST_IDLE;
            off_q     <= '0;
            lat_cnt_q <= '0;
            done_q    <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (start_ok) begin
                        off_q   <= '0;
                        state_q <= (mode_i == mem_pkg::MOVE_FILL) ? ST_WRITE : ST_READ;
                    end
                end
                ST_READ: begin
                    lat_cnt_q <= '0;
                    state_q   <= ST_WAIT;
                end
                ST_WAIT: begin
                    // data lands on the port in the write cycle.
                    if (int'(lat_cnt_q) == mem_pkg::RD_LAT - 2) begin
                        state_q <= ST_WRITE;
                    end else begin
                        lat_cnt_q <= lat_cnt_q + 1'b1;
                    end
                end
                ST_WRITE: begin
                    if (last_word) begin
                        done_q  <= 1'b1;
                        state_q <= ST_IDLE;
                    end else begin
                        off_q   <= off_q + 1'b1;
                        state_q <= (mode_q == mem_pkg::MOVE_FILL) ? ST_WRITE : ST_READ;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    always_comb begin
        port.en    = 1'b0;
        port.wr_en = '0;
        port.addr  = src_q + off_q;
        port.wdata = pattern_q;
        case (state_q)
            ST_READ: begin
                port.en = 1'b1;
            end
            ST_WRITE: begin
                port.en    = 1'b1;
                port.wr_en = '1;
                port.addr  = dst_q + off_q;
                if (mode_q == mem_pkg::MOVE_COPY) begin
                    port.wdata = port.rdata;
                end
            end
            default: begin
                port.en = 1'b0;
            end
        endcase
    end

    assign busy_o = (state_q != ST_IDLE);
    assign done_o = done_q;

    // destination range must not wrap past the top.
    a_dst_in_range: assert property (
        @(posedge a_clk_i) disable iff (!rst_n_i)
        busy_o |-> (({1'b0, dst_q} + len_q) <= mem_pkg::MEM_DEPTH)
    ) else $error("block_mover: destination range exceeds memory");

endmodule

// File: source/scratch_mem_top.sv
`timescale 1ns/10ps

module scratch_mem_top (
    input  logic                          a_clk_i,
    input  logic                          rst_n_i,

    input  logic                          host_en_i,
    input  mem_pkg::be_t                  host_wr_en_i,
    input  mem_pkg::addr_t                host_addr_i,
    input  mem_pkg::word_t                host_wdata_i,
    output mem_pkg::word_t                host_rdata_o,
    output logic                          host_rvalid_o,

    input  logic                          move_start_i,
    input  mem_pkg::move_mode_e           move_mode_i,
    input  mem_pkg::addr_t                move_src_i,
    input  mem_pkg::addr_t                move_dst_i,
    input  logic [mem_pkg::ADDR_WIDTH:0]  move_len_i,
    input  mem_pkg::word_t                move_pattern_i,
    output logic                          move_busy_o,
    output logic                          move_done_o
);

    ram_port_if port_a ();
    ram_port_if port_b ();

    host_port_ctrl host_port_ctrl_i (
        .a_clk_i       (a_clk_i),
        .rst_n_i       (rst_n_i),
        .host_en_i     (host_en_i),
        .host_wr_en_i  (host_wr_en_i),
        .host_addr_i   (host_addr_i),
        .host_wdata_i  (host_wdata_i),
        .host_rdata_o  (host_rdata_o),
        .host_rvalid_o (host_rvalid_o),
        .port          (port_a.master)
    );

    block_mover block_mover_i (
        .a_clk_i   (a_clk_i),
        .rst_n_i   (rst_n_i),
        .start_i   (move_start_i),
        .mode_i    (move_mode_i),
        .src_i     (move_src_i),
        .dst_i     (move_dst_i),
        .len_i     (move_len_i),
        .pattern_i (move_pattern_i),
        .busy_o    (move_busy_o),
        .done_o    (move_done_o),
        .port      (port_b.master)
    );

    // port a for the host, port b for the mover.
    ram_tdp ram_tdp_i (
        .a_clk_i (a_clk_i),
        .port_a  (port_a.slave),
        .port_b  (port_b.slave)
    );

endmodule

// File: tests/scratch_mem_tasks.svh
task automatic next_cycle();
    @(posedge a_clk);
    #1;
endtask

task automatic check_word(input string name, input mem_pkg::word_t got,
                          input mem_pkg::word_t exp);
    if (got !== exp) begin
        error_count++;
        $display("[FAIL] %0t %s got %08h expected %08h", $time, name, got, exp);
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        error_count++;
        $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
    end
endtask

task automatic expect_cycles(input string what, input int got, input int exp);
    if (got != exp) begin
        error_count++;
        $display("[FAIL] %0t %s got %0d cycles expected %0d", $time, what, got, exp);
    end
endtask

function automatic mem_pkg::word_t rand_word();
    return mem_pkg::word_t'($random(seed));
endfunction

task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (error_count == errors_before) begin
        $display("test %s: ok", name);
    end else begin
        tests_failed++;
        $display("test %s: %0d errors", name, error_count - errors_before);
    end
endtask

// only the enabled lanes change in the model.
task automatic host_write(input int addr, input mem_pkg::be_t be, input mem_pkg::word_t data);
    host_en    = 1'b1;
    host_wr_en = be;
    host_addr  = mem_pkg::addr_t'(addr);
    host_wdata = data;
    next_cycle();
    host_en    = 1'b0;
    host_wr_en = '0;
    for (int i = 0; i < mem_pkg::BYTE_NUM; i++) begin
        if (be[i]) begin
            ref_mem[addr][i*mem_pkg::BYTE_WIDTH +: mem_pkg::BYTE_WIDTH] =
                data[i*mem_pkg::BYTE_WIDTH +: mem_pkg::BYTE_WIDTH];
        end
    end
endtask

task automatic read_and_compare(input int addr);
    int waited;
    waited     = 0;
    host_en    = 1'b1;
    host_wr_en = '0;
    host_addr  = mem_pkg::addr_t'(addr);
    next_cycle();
    host_en = 1'b0;
    while (host_rvalid !== 1'b1 && waited < WAIT_LIMIT) begin
        next_cycle();
        waited++;
    end
    if (host_rvalid === 1'b1) begin
        check_word($sformatf("host_rdata_o[%0d]", addr), host_rdata, ref_mem[addr]);
    end else begin
        error_count++;
        $display("host read of address %0d got no valid pulse", addr);
    end
endtask

task automatic launch_move(input mem_pkg::move_mode_e mode, input int src, input int dst,
                           input int len, input mem_pkg::word_t pattern);
    move_start   = 1'b1;
    move_mode    = mode;
    move_src     = mem_pkg::addr_t'(src);
    move_dst     = mem_pkg::addr_t'(dst);
    move_len     = len[mem_pkg::ADDR_WIDTH:0];
    move_pattern = pattern;
    next_cycle();
    move_start   = 1'b0;
endtask

task automatic wait_move_done(output int cycles);
    cycles = 0;
    while (move_done !== 1'b1 && cycles < MOVE_LIMIT) begin
        next_cycle();
        cycles++;
    end
    if (move_done === 1'b1) begin
        check_bit("move_busy_o", move_busy, 1'b0);
    end else begin
        error_count++;
        $display("mover gave no done pulse within %0d cycles", MOVE_LIMIT);
    end
endtask

task automatic reset_state();
    int errors_before;
    errors_before = error_count;
    check_bit("host_rvalid_o", host_rvalid, 1'b0);
    check_bit("move_busy_o", move_busy, 1'b0);
    check_bit("move_done_o", move_done, 1'b0);
    report_test("reset state", errors_before);
endtask

task automatic byte_enable_writes();
    int errors_before;
    errors_before = error_count;
    for (int a = 0; a < 8; a++) begin
        host_write(a, 4'hf, rand_word());
        read_and_compare(a);
        host_write(a, mem_pkg::be_t'(1 << (a % 4)), rand_word());
        read_and_compare(a);
    end
    // two lanes at once.
    host_write(8, 4'b0101, rand_word());
    host_write(9, 4'b1010, rand_word());
    read_and_compare(8);
    read_and_compare(9);
    report_test("byte enables", errors_before);
endtask

task automatic read_latency();
    int errors_before;
    errors_before = error_count;
    host_en    = 1'b1;
    host_wr_en = '0;
    host_addr  = 10'd37;
    // k counts edges since the read was driven.
    for (int k = 1; k <= mem_pkg::RD_LAT + 2; k++) begin
        next_cycle();
        host_en = 1'b0;
        check_bit($sformatf("host_rvalid_o edge %0d", k), host_rvalid, k == mem_pkg::RD_LAT);
        if (k == mem_pkg::RD_LAT) begin
            check_word("host_rdata_o", host_rdata, ref_mem[37]);
        end
    end
    report_test("read latency", errors_before);
endtask

task automatic pipelined_reads();
    int errors_before;
    int issued;
    int received;
    int waited;
    int addr;
    int addr_q[$];
    errors_before = error_count;
    issued        = 0;
    received      = 0;
    waited        = 0;
    while (received < 16 && waited < WAIT_LIMIT) begin
        if (issued < 16) begin
            addr = int'($unsigned($random(seed)) % PRELOAD_WORDS);
            addr_q.push_back(addr);
            host_en    = 1'b1;
            host_wr_en = '0;
            host_addr  = mem_pkg::addr_t'(addr);
            issued++;
        end else begin
            host_en = 1'b0;
        end
        next_cycle();
        waited++;
        // once data starts, a gap is an error.
        if (received > 0 || host_rvalid === 1'b1) begin
            check_bit("host_rvalid_o", host_rvalid, 1'b1);
            if (host_rvalid === 1'b1 && addr_q.size() > 0) begin
                addr = addr_q.pop_front();
                check_word($sformatf("host_rdata_o[%0d]", addr), host_rdata, ref_mem[addr]);
            end
            received++;
        end
    end
    host_en = 1'b0;
    if (received < 16) begin
        error_count++;
        $display("only %0d of 16 pipelined reads returned", received);
    end
    report_test("pipelined reads", errors_before);
endtask

task automatic copy_block();
    int errors_before;
    int cycles;
    errors_before = error_count;
    for (int i = 0; i < 20; i++) begin
        host_write(32 + i, 4'hf, rand_word());
    end
    launch_move(mem_pkg::MOVE_COPY, 32, 64, 20, '0);
    check_bit("move_busy_o", move_busy, 1'b1);
    wait_move_done(cycles);
    expect_cycles("move_done_o after copy of 20 words", cycles, (mem_pkg::RD_LAT + 1) * 20);
    for (int i = 0; i < 20; i++) begin
        ref_mem[64 + i] = ref_mem[32 + i];
    end
    for (int a = 32; a < 84; a++) begin
        read_and_compare(a);
    end
    report_test("copy", errors_before);
endtask

task automatic fill_block();
    int errors_before;
    int cycles;
    mem_pkg::word_t pattern;
    errors_before = error_count;
    pattern       = rand_word();
    launch_move(mem_pkg::MOVE_FILL, 0, 96, 32, pattern);
    wait_move_done(cycles);
    expect_cycles("move_done_o after fill of 32 words", cycles, 32);
    for (int i = 0; i < 32; i++) begin
        ref_mem[96 + i] = pattern;
    end
    // one word either side must survive.
    for (int a = 95; a <= 128; a++) begin
        read_and_compare(a);
    end
    report_test("fill", errors_before);
endtask

task automatic start_while_busy();
    int errors_before;
    int cycles;
    int done_pulses;
    errors_before = error_count;
    launch_move(mem_pkg::MOVE_COPY, 0, 140, 10, '0);
    next_cycle();
    check_bit("move_busy_o", move_busy, 1'b1);
    launch_move(mem_pkg::MOVE_FILL, 0, 0, 8, rand_word());
    wait_move_done(cycles);
    done_pulses = (move_done === 1'b1) ? 1 : 0;
    // a fill that slipped through would end inside this window.
    for (int i = 0; i < 32; i++) begin
        next_cycle();
        if (move_done === 1'b1) begin
            done_pulses++;
        end
    end
    if (done_pulses != 1) begin
        error_count++;
        $display("[FAIL] %0t move_done_o pulses got %0d expected 1", $time, done_pulses);
    end
    for (int i = 0; i < 10; i++) begin
        ref_mem[140 + i] = ref_mem[i];
    end
    for (int a = 0; a < 10; a++) begin
        read_and_compare(a);
        read_and_compare(140 + a);
    end
    report_test("start while busy", errors_before);
endtask

// File: tests/tb_scratch_mem.sv
`timescale 1ns/10ps

module tb_scratch_mem;

    localparam int CLK_PERIOD    = 10;
    localparam int RESET_CYCLES  = 5;
    // bounds for the wait loops.
    localparam int WAIT_LIMIT    = 50;
    localparam int MOVE_LIMIT    = 2000;
    localparam int PRELOAD_WORDS = 160;

    logic                         a_clk;
    logic                         rst_n;
    logic                         host_en;
    mem_pkg::be_t                 host_wr_en;
    mem_pkg::addr_t               host_addr;
    mem_pkg::word_t               host_wdata;
    mem_pkg::word_t               host_rdata;
    logic                         host_rvalid;
    logic                         move_start;
    mem_pkg::move_mode_e          move_mode;
    mem_pkg::addr_t               move_src;
    mem_pkg::addr_t               move_dst;
    logic [mem_pkg::ADDR_WIDTH:0] move_len;
    mem_pkg::word_t               move_pattern;
    logic                         move_busy;
    logic                         move_done;

    // expected memory contents.
    mem_pkg::word_t ref_mem [mem_pkg::MEM_DEPTH];

    int seed;
    int error_count;
    int tests_run;
    int tests_failed;

    scratch_mem_top scratch_mem_top_i (
        .a_clk_i        (a_clk),
        .rst_n_i        (rst_n),
        .host_en_i      (host_en),
        .host_wr_en_i   (host_wr_en),
        .host_addr_i    (host_addr),
        .host_wdata_i   (host_wdata),
        .host_rdata_o   (host_rdata),
        .host_rvalid_o  (host_rvalid),
        .move_start_i   (move_start),
        .move_mode_i    (move_mode),
        .move_src_i     (move_src),
        .move_dst_i     (move_dst),
        .move_len_i     (move_len),
        .move_pattern_i (move_pattern),
        .move_busy_o    (move_busy),
        .move_done_o    (move_done)
    );

    initial begin
        a_clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) a_clk = ~a_clk;
        end
    end

    `include "scratch_mem_tasks.svh"

    initial begin
        seed         = 32'h296e;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        rst_n        = 1'b0;
        host_en      = 1'b0;
        host_wr_en   = '0;
        host_addr    = '0;
        host_wdata   = '0;
        move_start   = 1'b0;
        move_mode    = mem_pkg::MOVE_COPY;
        move_src     = '0;
        move_dst     = '0;
        move_len     = '0;
        move_pattern = '0;
        repeat (RESET_CYCLES) @(posedge a_clk);
        #1;
        rst_n = 1'b1;
        next_cycle();
        reset_state();
        // every address the tests touch gets a known word.
        for (int a = 0; a < PRELOAD_WORDS; a++) begin
            host_write(a, 4'hf, rand_word());
        end
        byte_enable_writes();
        read_latency();
        pipelined_reads();
        copy_block();
        fill_block();
        start_while_busy();
        $display("tests run %0d, tests failed %0d, failed checks %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+tests
source/mem_pkg.sv
source/ram_port_if.sv
source/ram_tdp.sv
source/host_port_ctrl.sv
source/block_mover.sv
source/scratch_mem_top.sv
tests/tb_scratch_mem.sv

// File: run_sim.sh
#!/bin/sh
# build and run the scratchpad testbench with verilator.

cd "$(dirname "$0")" || exit 1

log_file=sim.log
fail_msg='*** FAILED ***'

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_scratch_mem -f tb.f -o tb_scratch_mem
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_scratch_mem > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qF "$fail_msg" "$log_file"; then
    echo "testbench reported a failure"
    exit 1
fi

echo "testbench finished without a failure"
exit 0
